//--- flist.f
ysyx_pkg.sv
ysyx_idu.sv
ysyx_regfile.sv
ysyx_alu.sv
ysyx_lsu.sv
ysyx_bru.sv
ysyx_core.sv
ysyx_core_chk.sv
tb_ysyx_core.sv

//--- run.sh
#!/bin/sh
# build and run the simulation with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_ysyx_core -o sim
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- tb_ysyx_core.sv
// testbench for ysyx_core with clock, reset, handshake driver, reference model and directed tests
`timescale 1ns/1ps

module tb_ysyx_core;
  import ysyx_pkg::*;

  logic        clk;
  logic        i_rst;
  logic        i_req;
  logic [31:0] i_inst;
  logic        o_ack;
  logic [63:0] o_pc;
  logic        o_wb_en;
  logic [4:0]  o_wb_rd;
  logic [63:0] o_wb_data;
  logic        o_halt;
  logic        o_trap;

  logic [63:0] ref_regs [32];
  logic [7:0]  ref_mem [512];
  logic [63:0] ref_pc;
  logic [63:0] got_pc, got_data, got_en, got_rd, got_halt, got_trap;

  ysyx_core dut_i (
    .i_clk(clk), .i_rst(i_rst), .i_req(i_req), .i_inst(i_inst), .o_ack(o_ack),
    .o_pc(o_pc), .o_wb_en(o_wb_en), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data),
    .o_halt(o_halt), .o_trap(o_trap)
  );

  bind ysyx_core ysyx_core_chk chk_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_req(i_req), .i_ack(o_ack),
    .i_halt(o_halt), .i_trap(o_trap)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [63:0] imm12(input logic [11:0] x);
    return {{52{x[11]}}, x};
  endfunction

  function automatic logic [63:0] word(input logic [31:0] x);
    return {{32{x[31]}}, x};
  endfunction

  // encoders per format view of the union
  function automatic logic [31:0] r_type(input logic [6:0] op, f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
    inst_u w;
    w.r = {f7, rs2, rs1, f3, rd, op};
    return w;
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, input logic [11:0] imm);
    inst_u w;
    w.i = {imm, rs1, f3, rd, op};
    return w;
  endfunction

  function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                         input logic [11:0] imm);
    inst_u w;
    w.s = {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    return w;
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                         input logic [12:0] imm);
    inst_u w;
    w.b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    return w;
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [19:0] imm);
    inst_u w;
    w.u = {imm, rd, op};
    return w;
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
    inst_u w;
    w.j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    return w;
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED @ %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout: the DUT gave no %s within 20 cycles", what);
    $display("Test FAILED");
    $fatal(1, "handshake timeout");
  endtask

  task automatic reset_core();
    @(negedge clk);
    i_rst = 1'b1;
    i_req = 1'b0;
    repeat (3) @(negedge clk);
    i_rst  = 1'b0;
    ref_pc = '0;
    for (int k = 0; k < 32; k++) ref_regs[k] = '0;
    for (int k = 0; k < 512; k++) ref_mem[k] = '0;
  endtask

  // one four-phase handshake with req kept high for hold cycles after ack
  task automatic issue(input logic [31:0] inst, input int hold);
    int n;
    @(negedge clk);
    i_inst = inst;
    i_req  = 1'b1;
    n = 0;
    while (!o_ack && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!o_ack) timed_out("ack");
    check(64'(n), 64'd1, "ack latency");
    got_pc   = o_pc;
    got_data = o_wb_data;
    got_en   = 64'(o_wb_en);
    got_rd   = 64'(o_wb_rd);
    got_halt = 64'(o_halt);
    got_trap = 64'(o_trap);
    repeat (hold) @(negedge clk);
    check(64'(o_ack), 64'd1, "ack held");
    i_req = 1'b0;
    n = 0;
    while (o_ack && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (o_ack) timed_out("ack release");
  endtask

  task automatic retire(input logic [31:0] inst, input logic wr, input logic [4:0] rd,
                        input logic [63:0] val, input logic [63:0] npc, input int hold = 0);
    issue(inst, hold);
    check(got_en, 64'(wr), "wb_en");
    check(got_halt, 64'd0, "halt");
    check(got_trap, 64'd0, "trap");
    if (wr) begin
      check(got_rd, 64'(rd), "wb_rd");
      check(got_data, val, "wb_data");
      if (rd != 5'd0) ref_regs[rd] = val;
    end
    check(got_pc, npc, "pc");
    ref_pc = npc;
  endtask

  task automatic blocked(input logic [31:0] inst, input logic halt, input logic trap);
    issue(inst, 0);
    check(got_en, 64'd0, "wb_en while stopped");
    check(got_halt, 64'(halt), "halt");
    check(got_trap, 64'(trap), "trap");
    check(got_pc, ref_pc, "pc while stopped");
  endtask

  task automatic li32(input logic [4:0] rd, input logic [31:0] w);
    logic [19:0] hi;
    hi = 20'((w + 32'h800) >> 12); // round for the signed low part
    retire(u_type(OP_LUI, rd, hi), 1, rd, word({hi, 12'b0}), ref_pc + 4);
    retire(i_type(OP_IMM32, 3'b000, rd, rd, w[11:0]), 1, rd, word(w), ref_pc + 4);
  endtask

  // x31 is scratch
  task automatic load_imm(input logic [4:0] rd, input logic [63:0] v);
    li32(rd, v[63:32]);
    retire(i_type(OP_IMM, 3'b001, rd, rd, 12'd32), 1, rd, ref_regs[rd] << 32, ref_pc + 4);
    li32(5'd31, v[31:0]);
    retire(i_type(OP_IMM, 3'b001, 31, 31, 12'd32), 1, 31, ref_regs[31] << 32, ref_pc + 4);
    retire(i_type(OP_IMM, 3'b101, 31, 31, 12'd32), 1, 31, ref_regs[31] >> 32, ref_pc + 4);
    retire(r_type(OP_REG, 7'h00, 3'b110, rd, rd, 31), 1, rd, ref_regs[rd] | ref_regs[31],
           ref_pc + 4);
  endtask

  task automatic arith_ops();
    logic [63:0] a, b, si;
    logic [5:0]  sh;
    load_imm(5, {$urandom, $urandom});
    load_imm(6, {$urandom, $urandom});
    a  = ref_regs[5];
    b  = ref_regs[6];
    sh = b[5:0];
    si = imm12(12'h9a5);
    retire(r_type(OP_REG, 7'h00, 3'b000, 10, 5, 6), 1, 10, a + b, ref_pc + 4);
    retire(r_type(OP_REG, 7'h20, 3'b000, 10, 5, 6), 1, 10, a - b, ref_pc + 4);
    retire(r_type(OP_REG, 7'h00, 3'b010, 10, 5, 6), 1, 10, 64'($signed(a) < $signed(b)),
           ref_pc + 4);
    retire(r_type(OP_REG, 7'h00, 3'b011, 10, 5, 6), 1, 10, 64'(a < b), ref_pc + 4);
    retire(r_type(OP_REG, 7'h00, 3'b100, 10, 5, 6), 1, 10, a ^ b, ref_pc + 4);
    retire(r_type(OP_REG, 7'h00, 3'b110, 10, 5, 6), 1, 10, a | b, ref_pc + 4);
    retire(r_type(OP_REG, 7'h00, 3'b111, 10, 5, 6), 1, 10, a & b, ref_pc + 4);
    retire(r_type(OP_REG, 7'h00, 3'b001, 10, 5, 6), 1, 10, a << sh, ref_pc + 4);
    retire(r_type(OP_REG, 7'h00, 3'b101, 10, 5, 6), 1, 10, a >> sh, ref_pc + 4);
    retire(r_type(OP_REG, 7'h20, 3'b101, 10, 5, 6), 1, 10, $signed(a) >>> sh, ref_pc + 4);
    retire(i_type(OP_IMM, 3'b000, 11, 5, 12'h9a5), 1, 11, a + si, ref_pc + 4);
    retire(i_type(OP_IMM, 3'b010, 11, 5, 12'h9a5), 1, 11, 64'($signed(a) < $signed(si)),
           ref_pc + 4);
    retire(i_type(OP_IMM, 3'b011, 11, 5, 12'h9a5), 1, 11, 64'(a < si), ref_pc + 4);
    retire(i_type(OP_IMM, 3'b100, 11, 5, 12'h9a5), 1, 11, a ^ si, ref_pc + 4);
    retire(i_type(OP_IMM, 3'b110, 11, 5, 12'h9a5), 1, 11, a | si, ref_pc + 4);
    retire(i_type(OP_IMM, 3'b111, 11, 5, 12'h9a5), 1, 11, a & si, ref_pc + 4);
    retire(i_type(OP_IMM, 3'b001, 11, 5, {6'b0, 6'd37}), 1, 11, a << 37, ref_pc + 4);
    retire(i_type(OP_IMM, 3'b101, 11, 5, {6'b0, 6'd37}), 1, 11, a >> 37, ref_pc + 4);
    retire(i_type(OP_IMM, 3'b101, 11, 5, {6'b010000, 6'd45}), 1, 11, $signed(a) >>> 45,
           ref_pc + 4);
    retire(u_type(OP_AUIPC, 12, 20'hfedcb), 1, 12, ref_pc + word({20'hfedcb, 12'b0}),
           ref_pc + 4);
    // x0 swallows the write
    retire(i_type(OP_IMM, 3'b000, 0, 5, 12'd1), 1, 0, a + 1, ref_pc + 4);
    retire(r_type(OP_REG, 7'h00, 3'b000, 13, 0, 0), 1, 13, 64'd0, ref_pc + 4);
  endtask

  task automatic word_ops();
    logic [63:0] a, b, si;
    load_imm(7, {$urandom & 32'h7fff_ffff, $urandom | 32'h8000_0000});
    load_imm(8, {$urandom | 32'h8000_0000, $urandom & 32'h7fff_ffff});
    a  = ref_regs[7];
    b  = ref_regs[8];
    si = imm12(12'h876);
    retire(i_type(OP_IMM32, 3'b000, 14, 7, 12'h876), 1, 14, word(a[31:0] + si[31:0]),
           ref_pc + 4);
    retire(r_type(OP_REG32, 7'h00, 3'b000, 14, 7, 8), 1, 14, word(a[31:0] + b[31:0]),
           ref_pc + 4);
    retire(r_type(OP_REG32, 7'h20, 3'b000, 14, 7, 8), 1, 14, word(a[31:0] - b[31:0]),
           ref_pc + 4);
    retire(r_type(OP_REG32, 7'h00, 3'b001, 14, 7, 8), 1, 14, word(a[31:0] << b[4:0]),
           ref_pc + 4);
    retire(r_type(OP_REG32, 7'h00, 3'b101, 14, 7, 8), 1, 14, word(a[31:0] >> b[4:0]),
           ref_pc + 4);
    retire(r_type(OP_REG32, 7'h20, 3'b101, 14, 7, 8), 1, 14,
           word($signed(a[31:0]) >>> b[4:0]), ref_pc + 4);
    retire(i_type(OP_IMM32, 3'b001, 14, 8, 12'd7), 1, 14, word(b[31:0] << 7), ref_pc + 4);
    retire(i_type(OP_IMM32, 3'b101, 14, 7, 12'd9), 1, 14, word(a[31:0] >> 9), ref_pc + 4);
    retire(i_type(OP_IMM32, 3'b101, 14, 7, 12'h409), 1, 14, word($signed(a[31:0]) >>> 9),
           ref_pc + 4);
  endtask

  task automatic store(input logic [2:0] f3, input logic [4:0] rs2, input logic [11:0] off);
    logic [63:0] addr, v;
    addr = ref_regs[20] + imm12(off);
    v    = ref_regs[rs2];
    retire(s_type(f3, 20, rs2, off), 0, 0, 64'd0, ref_pc + 4);
    for (int k = 0; k < (1 << f3[1:0]); k++) ref_mem[addr[8:0] + k] = v[8*k +: 8];
  endtask

  task automatic load(input logic [2:0] f3, input logic [4:0] rd, input logic [11:0] off);
    logic [63:0] addr, v;
    int          size;
    addr = ref_regs[20] + imm12(off);
    size = 1 << f3[1:0];
    v    = '0;
    for (int k = 0; k < size; k++) v[8*k +: 8] = ref_mem[addr[8:0] + k];
    if (!f3[2] && size < 8 && v[8*size-1]) v = v | (~64'd0 << (8 * size)); // sign fill
    retire(i_type(OP_LOAD, f3, rd, 20, off), 1, rd, v, ref_pc + 4);
  endtask

  task automatic mem_ops();
    retire(i_type(OP_IMM, 3'b000, 20, 0, 12'h100), 1, 20, 64'h100, ref_pc + 4);
    load_imm(21, {$urandom, $urandom});
    load_imm(22, {$urandom, $urandom} | 64'h8080_8080_8080_8080);
    store(3'b011, 21, 12'd0);
    store(3'b011, 21, 12'd8);
    store(3'b011, 21, 12'd16);
    store(3'b000, 22, 12'd3);
    load(3'b000, 24, 12'd3);
    load(3'b100, 25, 12'd3);
    load(3'b011, 26, 12'd0);
    store(3'b001, 22, 12'd10);
    load(3'b001, 24, 12'd10);
    load(3'b101, 25, 12'd10);
    load(3'b011, 26, 12'd8);
    store(3'b010, 22, 12'd20);
    load(3'b010, 24, 12'd20);
    load(3'b110, 25, 12'd20);
    load(3'b011, 26, 12'd16);
    store(3'b011, 22, 12'd24);
    load(3'b011, 24, 12'd24);
    // negative offsets from a new base
    retire(i_type(OP_IMM, 3'b000, 20, 0, 12'h130), 1, 20, 64'h130, ref_pc + 4);
    store(3'b000, 22, 12'hffb);
    load(3'b100, 24, 12'hffb);
    load(3'b011, 26, 12'hff8);
  endtask

  task automatic cond_branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                             input logic [12:0] off);
    logic [63:0] a, b;
    logic        taken;
    a = ref_regs[rs1];
    b = ref_regs[rs2];
    case (f3)
      3'b000:  taken = (a == b);
      3'b001:  taken = (a != b);
      3'b100:  taken = ($signed(a) < $signed(b));
      3'b101:  taken = ($signed(a) >= $signed(b));
      3'b110:  taken = (a < b);
      default: taken = (a >= b);
    endcase
    retire(b_type(f3, rs1, rs2, off), 0, 0, 64'd0,
           taken ? ref_pc + {{51{off[12]}}, off} : ref_pc + 4);
  endtask

  task automatic branch_ops();
    logic [2:0] codes [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    load_imm(5, {$urandom | 32'h8000_0000, $urandom}); // negative
    load_imm(6, {32'h0, $urandom});
    for (int k = 0; k < 6; k++) begin
      cond_branch(codes[k], 5, 6, 13'd16);
      cond_branch(codes[k], 6, 5, 13'h1ff8);
      cond_branch(codes[k], 5, 5, 13'd12);
    end
    retire(j_type(1, 21'h1ffff0), 1, 1, ref_pc + 4, ref_pc - 64'd16);
    retire(j_type(1, 21'h000800), 1, 1, ref_pc + 4, ref_pc + 64'h800);
    // odd target with bit 0 dropped
    retire(i_type(OP_JALR, 3'b000, 2, 20, 12'h035), 1, 2, ref_pc + 4,
           (ref_regs[20] + 64'h35) & ~64'd1);
  endtask

  task automatic backpressure();
    retire(i_type(OP_IMM, 3'b000, 3, 3, 12'd1), 1, 3, ref_regs[3] + 1, ref_pc + 4, 6);
    retire(i_type(OP_IMM, 3'b000, 4, 3, 12'd0), 1, 4, ref_regs[3], ref_pc + 4);
  endtask

  task automatic halt_trap();
    logic [31:0] bad [4];
    bad[0] = r_type(OP_REG, 7'h01, 3'b000, 1, 2, 3);     // mul
    bad[1] = r_type(OP_REG, 7'h01, 3'b100, 1, 2, 3);     // div
    bad[2] = i_type(OP_SYSTEM, 3'b001, 1, 2, 12'h305);   // csrrw
    bad[3] = 32'h0000_00ff;                              // undefined opcode
    for (int k = 0; k < 4; k++) begin
      reset_core();
      blocked(bad[k], 0, 1);
      blocked(i_type(OP_IMM, 3'b000, 1, 0, 12'd5), 0, 1);
    end
    reset_core();
    blocked(32'h0010_0073, 1, 0); // ebreak
    blocked(i_type(OP_IMM, 3'b000, 1, 0, 12'd5), 1, 0);
  endtask

  initial begin
    i_rst  = 1'b1;
    i_req  = 1'b0;
    i_inst = '0;
    void'($urandom(32'h8b96f79f));
    reset_core();
    arith_ops();
    word_ops();
    mem_ops();
    branch_ops();
    backpressure();
    halt_trap();
    $display("Test OK");
    $finish;
  end

endmodule

//--- ysyx_alu.sv
// 64-bit ALU with 32-bit word cut, equality and less-than flags
`timescale 1ns/1ps

module ysyx_alu (
  input  logic [63:0] i_a,
  input  logic [63:0] i_b,
  input  logic [4:0]  i_ctr,
  input  logic        i_word_cut,
  output logic [63:0] o_result,
  output logic        o_zero,
  output logic        o_less
);
  import ysyx_pkg::*;

  logic [5:0]  shamt;
  logic [63:0] a_srl;
  logic [63:0] a_sra;
  logic [63:0] res;
  logic        lt_s;
  logic        lt_u;

  // word forms shift the low word by 5 bits
  assign shamt = i_word_cut ? {1'b0, i_b[4:0]} : i_b[5:0];
  assign a_srl = i_word_cut ? {32'b0, i_a[31:0]} : i_a;
  assign a_sra = i_word_cut ? {{32{i_a[31]}}, i_a[31:0]} : i_a;

  assign lt_s   = $signed(i_a) < $signed(i_b);
  assign lt_u   = i_a < i_b;
  assign o_less = (i_ctr == ALU_SLTU) ? lt_u : lt_s;
  assign o_zero = (i_a == i_b);

  always_comb begin
    case (i_ctr)
      ALU_ADD:   res = i_a + i_b;
      ALU_SUB:   res = i_a - i_b;
      ALU_SLT:   res = {63'b0, lt_s};
      ALU_SLTU:  res = {63'b0, lt_u};
      ALU_XOR:   res = i_a ^ i_b;
      ALU_AND:   res = i_a & i_b;
      ALU_OR:    res = i_a | i_b;
      ALU_SLL:   res = i_a << shamt;
      ALU_SRL:   res = a_srl >> shamt;
      ALU_SRA:   res = $signed(a_sra) >>> shamt;
      ALU_COPYB: res = i_b; // lui
      default:   res = '0;  // mul/div/csr not executed here
    endcase
  end

  assign o_result = i_word_cut ? {{32{res[31]}}, res[31:0]} : res;

endmodule

//--- ysyx_bru.sv
// next-PC selection for jumps and conditional branches
`timescale 1ns/1ps

module ysyx_bru (
  input  logic [63:0] i_pc,
  input  logic [63:0] i_imm,
  input  logic [63:0] i_rs1,
  input  logic [2:0]  i_branch,
  input  logic        i_zero,
  input  logic        i_less,
  output logic [63:0] o_next_pc
);
  import ysyx_pkg::*;

  logic        taken;
  logic [63:0] jalr_tgt;

  always_comb begin
    case (i_branch)
      BR_JAL:  taken = 1'b1;
      BR_EQ:   taken = i_zero;
      BR_NE:   taken = !i_zero;
      BR_LT:   taken = i_less;
      BR_GE:   taken = !i_less;
      default: taken = 1'b0;
    endcase
  end

  assign jalr_tgt  = i_rs1 + i_imm;
  assign o_next_pc = (i_branch == BR_JALR) ? {jalr_tgt[63:1], 1'b0} :
                     taken ? i_pc + i_imm : i_pc + 64'd4;

endmodule

//--- ysyx_core.sv
// core top: req/ack handshake, PC register, operand and writeback muxes, result registers
`timescale 1ns/1ps

module ysyx_core (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_req,
  input  logic [31:0] i_inst,
  output logic        o_ack,
  output logic [63:0] o_pc,
  output logic        o_wb_en,
  output logic [4:0]  o_wb_rd,
  output logic [63:0] o_wb_data,
  output logic        o_halt,
  output logic        o_trap
);
  import ysyx_pkg::*;

  logic [63:0] imm;
  logic [4:0]  ra, rb, rd;
  logic [2:0]  branch;
  logic [2:0]  mem_op;
  logic        alu_asrc;
  logic [1:0]  alu_bsrc;
  logic [4:0]  alu_ctr;
  logic        word_cut, reg_wr, mem_to_reg, mem_wr;
  logic [63:0] rs1_data, rs2_data;
  logic [63:0] alu_a, alu_b, alu_res;
  logic        alu_zero, alu_less;
  logic [63:0] load_data, wb_data, next_pc;
  logic        commit, stopped, is_trap, is_halt, exec;
  logic        we_reg, we_mem;

  ysyx_idu idu_i (
    .i_inst(i_inst), .o_imm(imm), .o_ra(ra), .o_rb(rb), .o_rd(rd),
    .o_branch(branch), .o_alu_asrc(alu_asrc), .o_alu_bsrc(alu_bsrc),
    .o_alu_ctr(alu_ctr), .o_word_cut(word_cut), .o_reg_wr(reg_wr),
    .o_mem_to_reg(mem_to_reg), .o_mem_wr(mem_wr), .o_mem_op(mem_op)
  );

  ysyx_regfile regfile_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_we(we_reg), .i_waddr(rd), .i_wdata(wb_data),
    .i_raddr_a(ra), .i_raddr_b(rb), .o_rdata_a(rs1_data), .o_rdata_b(rs2_data)
  );

  assign alu_a = alu_asrc ? o_pc : rs1_data;

  always_comb begin
    case (alu_bsrc)
      BSRC_IMM:  alu_b = imm;
      BSRC_FOUR: alu_b = 64'd4; // link address
      default:   alu_b = rs2_data;
    endcase
  end

  ysyx_alu alu_i (
    .i_a(alu_a), .i_b(alu_b), .i_ctr(alu_ctr), .i_word_cut(word_cut),
    .o_result(alu_res), .o_zero(alu_zero), .o_less(alu_less)
  );

  ysyx_lsu lsu_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_addr(alu_res), .i_wdata(rs2_data),
    .i_we(we_mem), .i_mem_op(mem_op), .o_rdata(load_data)
  );

  ysyx_bru bru_i (
    .i_pc(o_pc), .i_imm(imm), .i_rs1(rs1_data), .i_branch(branch),
    .i_zero(alu_zero), .i_less(alu_less), .o_next_pc(next_pc)
  );

  assign wb_data = mem_to_reg ? load_data : alu_res;

  // o_ack doubles as the IDLE/ACK state bit
  assign commit  = i_req && !o_ack;
  assign stopped = o_halt || o_trap; // sticky, later instructions ignored
  assign is_halt = (alu_ctr == ALU_EBREAK);
  assign is_trap = alu_ctr inside {ALU_MUL, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
                                   ALU_CSR, ALU_INVALID};
  assign exec    = commit && !stopped && !is_halt && !is_trap;
  assign we_reg  = exec && reg_wr;
  assign we_mem  = exec && mem_wr;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_ack   <= 1'b0;
      o_wb_en <= 1'b0;
      o_halt  <= 1'b0;
      o_trap  <= 1'b0;
      o_pc    <= '0;
    end else if (commit) begin
      o_ack   <= 1'b1;
      o_wb_en <= we_reg;
      o_halt  <= o_halt || (!stopped && is_halt);
      o_trap  <= o_trap || (!stopped && is_trap);
      if (exec) o_pc <= next_pc;
    end else if (o_ack && !i_req) begin
      o_ack <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (commit) begin
      o_wb_rd   <= rd;
      o_wb_data <= wb_data;
    end
  end

endmodule

//--- ysyx_core_chk.sv
// concurrent handshake and reset assertions for the core, bound into ysyx_core
`timescale 1ns/1ps

module ysyx_core_chk (
  input logic i_clk,
  input logic i_rst,
  input logic i_req,
  input logic i_ack,
  input logic i_halt,
  input logic i_trap
);

  // ack only answers a live request
  ack_needs_req: assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(i_ack) |-> $past(i_req))
    else $error("ack rose without a request");

  ack_latency: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_req && !i_ack) |=> i_ack)
    else $error("ack not raised one cycle after the request");

  // held until the request drops
  ack_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_ack && i_req) |=> i_ack)
    else $error("ack dropped while the request was still high");

  reset_state: assert property (@(posedge i_clk)
    i_rst |=> (!i_ack && !i_halt && !i_trap))
    else $error("ack, halt or trap high after reset");

endmodule

//--- ysyx_idu.sv
// instruction decode unit: field extraction, immediate generation, control signals
`timescale 1ns/1ps

module ysyx_idu (
  input  logic [31:0] i_inst,
  output logic [63:0] o_imm,
  output logic [4:0]  o_ra,
  output logic [4:0]  o_rb,
  output logic [4:0]  o_rd,
  output logic [2:0]  o_branch,
  output logic        o_alu_asrc,
  output logic [1:0]  o_alu_bsrc,
  output logic [4:0]  o_alu_ctr,
  output logic        o_word_cut,
  output logic        o_reg_wr,
  output logic        o_mem_to_reg,
  output logic        o_mem_wr,
  output logic [2:0]  o_mem_op
);
  import ysyx_pkg::*;

  inst_u       inst;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [63:0] imm_i;
  logic [63:0] imm_s;
  logic [63:0] imm_b;
  logic [63:0] imm_u;
  logic [63:0] imm_j;
  logic        valid;
  logic        jump;

  assign inst   = i_inst;
  assign opcode = inst.r.opcode;
  assign funct3 = inst.r.funct3;
  assign funct7 = inst.r.funct7;
  assign o_ra   = inst.r.rs1;
  assign o_rb   = inst.r.rs2;
  assign o_rd   = inst.r.rd;

  // sign-extended immediates, one per format view
  assign imm_i = {{52{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{52{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_b = {{52{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5, inst.b.imm4_1, 1'b0};
  assign imm_u = {{32{inst.u.imm[19]}}, inst.u.imm, 12'b0};
  assign imm_j = {{44{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11, inst.j.imm10_1, 1'b0};

  always_comb begin
    o_alu_ctr  = ALU_INVALID;
    o_branch   = BR_NONE;
    o_mem_op   = MEM_NONE;
    o_word_cut = 1'b0;
    o_imm      = imm_i;
    case (opcode)
      OP_LUI: begin
        o_alu_ctr = ALU_COPYB;
        o_imm     = imm_u;
      end
      OP_AUIPC: begin
        o_alu_ctr = ALU_ADD;
        o_imm     = imm_u;
      end
      OP_JAL: begin
        o_alu_ctr = ALU_ADD; // link = pc + 4
        o_branch  = BR_JAL;
        o_imm     = imm_j;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) begin
          o_alu_ctr = ALU_ADD;
          o_branch  = BR_JALR;
        end
      end
      OP_BRANCH: begin
        o_imm = imm_b;
        if (funct3[2:1] != 2'b01) begin
          o_alu_ctr = funct3[1] ? ALU_SLTU : ALU_SLT;
          case ({funct3[2], funct3[0]})
            2'b00:   o_branch = BR_EQ;
            2'b01:   o_branch = BR_NE;
            2'b10:   o_branch = BR_LT;
            default: o_branch = BR_GE;
          endcase
        end
      end
      OP_LOAD: begin
        case (funct3)
          3'b000:  o_mem_op = MEM_B;
          3'b001:  o_mem_op = MEM_H;
          3'b010:  o_mem_op = MEM_W;
          3'b011:  o_mem_op = MEM_D;
          3'b100:  o_mem_op = MEM_BU;
          3'b101:  o_mem_op = MEM_HU;
          3'b110:  o_mem_op = MEM_WU;
          default: o_mem_op = MEM_NONE;
        endcase
        if (o_mem_op != MEM_NONE) o_alu_ctr = ALU_ADD;
      end
      OP_STORE: begin
        o_imm = imm_s;
        if (!funct3[2]) begin
          o_alu_ctr = ALU_ADD;
          case (funct3[1:0])
            2'b00:   o_mem_op = MEM_B;
            2'b01:   o_mem_op = MEM_H;
            2'b10:   o_mem_op = MEM_W;
            default: o_mem_op = MEM_D;
          endcase
        end
      end
      OP_IMM: begin
        case (funct3)
          3'b000: o_alu_ctr = ALU_ADD;
          3'b010: o_alu_ctr = ALU_SLT;
          3'b011: o_alu_ctr = ALU_SLTU;
          3'b100: o_alu_ctr = ALU_XOR;
          3'b110: o_alu_ctr = ALU_OR;
          3'b111: o_alu_ctr = ALU_AND;
          3'b001: if (funct7[6:1] == 6'b000000) o_alu_ctr = ALU_SLL;
          default: begin // 6-bit shamt, funct7[0] is shamt[5]
            if (funct7[6:1] == 6'b000000) o_alu_ctr = ALU_SRL;
            else if (funct7[6:1] == 6'b010000) o_alu_ctr = ALU_SRA;
          end
        endcase
      end
      OP_IMM32: begin
        o_word_cut = 1'b1;
        if (funct3 == 3'b000) o_alu_ctr = ALU_ADD;
        else if ({funct7, funct3} == 10'b0000000_001) o_alu_ctr = ALU_SLL;
        else if ({funct7, funct3} == 10'b0000000_101) o_alu_ctr = ALU_SRL;
        else if ({funct7, funct3} == 10'b0100000_101) o_alu_ctr = ALU_SRA;
      end
      OP_REG, OP_REG32: begin
        o_word_cut = (opcode == OP_REG32);
        case ({funct7, funct3})
          10'b0000000_000: o_alu_ctr = ALU_ADD;
          10'b0100000_000: o_alu_ctr = ALU_SUB;
          10'b0000000_001: o_alu_ctr = ALU_SLL;
          10'b0000000_010: o_alu_ctr = ALU_SLT;
          10'b0000000_011: o_alu_ctr = ALU_SLTU;
          10'b0000000_100: o_alu_ctr = ALU_XOR;
          10'b0000000_101: o_alu_ctr = ALU_SRL;
          10'b0100000_101: o_alu_ctr = ALU_SRA;
          10'b0000000_110: o_alu_ctr = ALU_OR;
          10'b0000000_111: o_alu_ctr = ALU_AND;
          10'b0000001_000: o_alu_ctr = ALU_MUL;
          10'b0000001_100: o_alu_ctr = ALU_DIV;
          10'b0000001_101: o_alu_ctr = ALU_DIVU;
          10'b0000001_110: o_alu_ctr = ALU_REM;
          10'b0000001_111: o_alu_ctr = ALU_REMU;
          default:         o_alu_ctr = ALU_INVALID;
        endcase
        // no slt/sltu/logic ops in the word form
        if (o_word_cut && funct7 == 7'b0 && funct3 inside {3'b010, 3'b011, 3'b100, 3'b110, 3'b111})
          o_alu_ctr = ALU_INVALID;
      end
      OP_SYSTEM: begin
        if (funct3 == 3'b000 && inst.i.imm == 12'h001) o_alu_ctr = ALU_EBREAK;
        else if (funct3 == 3'b001) o_alu_ctr = ALU_CSR; // csrrw
      end
      default: o_alu_ctr = ALU_INVALID;
    endcase
  end

  assign valid        = (o_alu_ctr != ALU_INVALID);
  assign jump         = valid && (opcode == OP_JAL || opcode == OP_JALR);
  assign o_reg_wr     = valid && opcode != OP_BRANCH && opcode != OP_STORE;
  assign o_mem_to_reg = valid && opcode == OP_LOAD;
  assign o_mem_wr     = valid && opcode == OP_STORE;
  assign o_alu_asrc   = jump || (valid && opcode == OP_AUIPC); // pc as operand a
  assign o_alu_bsrc   = jump ? BSRC_FOUR :
                        (opcode inside {OP_BRANCH, OP_REG, OP_REG32}) ? BSRC_RS2 : BSRC_IMM;

endmodule

//--- ysyx_lsu.sv
// 64 x 64 data memory with byte-lane stores and sign/zero-extending loads
`timescale 1ns/1ps

module ysyx_lsu (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic [63:0] i_addr,
  input  logic [63:0] i_wdata,
  input  logic        i_we,
  input  logic [2:0]  i_mem_op,
  output logic [63:0] o_rdata
);
  import ysyx_pkg::*;

  logic [63:0] mem [64];
  logic [5:0]  idx;
  logic [5:0]  bit_ofs;
  logic [7:0]  size_mask;
  logic [7:0]  lane_en;
  logic [63:0] wdata_sh;
  logic [63:0] rd_sh;

  assign idx     = i_addr[8:3];
  assign bit_ofs = {i_addr[2:0], 3'b000};

  always_comb begin
    case (i_mem_op)
      MEM_B, MEM_BU: size_mask = 8'h01;
      MEM_H, MEM_HU: size_mask = 8'h03;
      MEM_W, MEM_WU: size_mask = 8'h0f;
      MEM_D:         size_mask = 8'hff;
      default:       size_mask = 8'h00;
    endcase
  end

  // lanes past the doubleword boundary fall off
  assign lane_en  = size_mask << i_addr[2:0];
  assign wdata_sh = i_wdata << bit_ofs;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int k = 0; k < 64; k++) begin
        mem[k] <= '0;
      end
    end else if (i_we) begin
      for (int b = 0; b < 8; b++) begin
        if (lane_en[b]) mem[idx][8*b +: 8] <= wdata_sh[8*b +: 8];
      end
    end
  end

  assign rd_sh = mem[idx] >> bit_ofs;

  always_comb begin
    case (i_mem_op)
      MEM_B:   o_rdata = {{56{rd_sh[7]}}, rd_sh[7:0]};
      MEM_BU:  o_rdata = {56'b0, rd_sh[7:0]};
      MEM_H:   o_rdata = {{48{rd_sh[15]}}, rd_sh[15:0]};
      MEM_HU:  o_rdata = {48'b0, rd_sh[15:0]};
      MEM_W:   o_rdata = {{32{rd_sh[31]}}, rd_sh[31:0]};
      MEM_WU:  o_rdata = {32'b0, rd_sh[31:0]};
      default: o_rdata = rd_sh; // ld
    endcase
  end

endmodule

//--- ysyx_pkg.sv
// opcodes, ALU/branch/memory-op/operand-source codes and the instruction format union
package ysyx_pkg;

  // major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG32  = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // ALU control
  localparam logic [4:0] ALU_ADD     = 5'b00000;
  localparam logic [4:0] ALU_SUB     = 5'b00001;
  localparam logic [4:0] ALU_SLT     = 5'b00010; // also signed branch compare
  localparam logic [4:0] ALU_SLTU    = 5'b00011; // also unsigned branch compare
  localparam logic [4:0] ALU_XOR     = 5'b00100;
  localparam logic [4:0] ALU_AND     = 5'b00101;
  localparam logic [4:0] ALU_OR      = 5'b00110;
  localparam logic [4:0] ALU_SLL     = 5'b00111;
  localparam logic [4:0] ALU_SRL     = 5'b01000;
  localparam logic [4:0] ALU_SRA     = 5'b01001;
  localparam logic [4:0] ALU_MUL     = 5'b01010;
  localparam logic [4:0] ALU_DIV     = 5'b01011;
  localparam logic [4:0] ALU_DIVU    = 5'b01100;
  localparam logic [4:0] ALU_REM     = 5'b01101;
  localparam logic [4:0] ALU_REMU    = 5'b01110;
  localparam logic [4:0] ALU_COPYB   = 5'b01111;
  localparam logic [4:0] ALU_CSR     = 5'b10000;
  localparam logic [4:0] ALU_EBREAK  = 5'b11110;
  localparam logic [4:0] ALU_INVALID = 5'b11111;

  // branch codes, LT/GE take signedness from the ALU compare
  localparam logic [2:0] BR_NONE = 3'b000;
  localparam logic [2:0] BR_JAL  = 3'b001;
  localparam logic [2:0] BR_JALR = 3'b010;
  localparam logic [2:0] BR_EQ   = 3'b100;
  localparam logic [2:0] BR_NE   = 3'b101;
  localparam logic [2:0] BR_LT   = 3'b110;
  localparam logic [2:0] BR_GE   = 3'b111;

  // memory access size and sign
  localparam logic [2:0] MEM_B    = 3'b000;
  localparam logic [2:0] MEM_BU   = 3'b001;
  localparam logic [2:0] MEM_H    = 3'b010;
  localparam logic [2:0] MEM_HU   = 3'b011;
  localparam logic [2:0] MEM_W    = 3'b100;
  localparam logic [2:0] MEM_WU   = 3'b101;
  localparam logic [2:0] MEM_D    = 3'b110;
  localparam logic [2:0] MEM_NONE = 3'b111;

  // ALU operand B source
  localparam logic [1:0] BSRC_RS2  = 2'b00;
  localparam logic [1:0] BSRC_IMM  = 2'b01;
  localparam logic [1:0] BSRC_FOUR = 2'b10;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_u;

endpackage

//--- ysyx_regfile.sv
// 32 x 64 register file, two combinational reads, one write, x0 fixed at zero
`timescale 1ns/1ps

module ysyx_regfile (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_we,
  input  logic [4:0]  i_waddr,
  input  logic [63:0] i_wdata,
  input  logic [4:0]  i_raddr_a,
  input  logic [4:0]  i_raddr_b,
  output logic [63:0] o_rdata_a,
  output logic [63:0] o_rdata_b
);

  logic [63:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (i_we && i_waddr != 5'd0) begin // x0 never written
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata_a = regs[i_raddr_a];
  assign o_rdata_b = regs[i_raddr_b];

endmodule
